// File: src/tm1638_pkg.sv
`default_nettype none

package tm1638_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // timing

    localparam int clk_mhz      = 10;    // system clock of the simulation build
    localparam int sio_half_div = 4;     // clk cycles per sio_clk half period
    localparam int tick_cycles  = 4096;  // slow tick period, longer than a refresh
    localparam int gap_cycles   = 16;    // idle cycles closing each refresh

    localparam int n_digits     = 8;     // digits, leds and keys on the module
    localparam int n_key_bytes  = 4;     // bytes returned by one key scan

    ////////////////////////////////////////////////////////////////////////////
    // TM1638 command bytes

    typedef enum logic [7:0] {
        cmd_write_auto = 8'h40,          // data write, auto increment address
        cmd_read_keys  = 8'h42,          // key scan read
        cmd_addr_zero  = 8'hC0,          // set address to 0
        cmd_display_on = 8'h8F           // display on at full brightness
    } tm_cmd_t;

    typedef enum logic [2:0] {
        st_idle,
        st_mode,
        st_addr,
        st_data,
        st_disp,
        st_read_cmd,
        st_read,
        st_gap
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: src/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen
(
    input  wire  clk,
    input  wire  rst_n,
    output logic tick
);

    logic [$clog2(tm1638_pkg::tick_cycles) - 1:0] cnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            tick <= 1'b0;
            if (int'(cnt) == tm1638_pkg::tick_cycles - 1)
            begin
                cnt  <= '0;
                tick <= 1'b1;                    // one cycle strobe on the wrap
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/lab_top.sv
`timescale 1ns/1ps
`default_nettype none

module lab_top
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        tick,
    input  wire  [7:0] key,
    output logic [7:0] led,
    output logic [7:0] abcdefgh,
    output logic [7:0] digit
);

    logic [31:0] count;
    logic [ 3:0] nibble;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
            digit <= 8'b0000_0001;
            led   <= '0;
        end
        else
        begin
            if (tick)
                count <= count + 1'b1;
            digit <= {digit[tm1638_pkg::n_digits - 2:0], digit[tm1638_pkg::n_digits - 1]};
            led   <= key;                        // keys mirrored one cycle later
        end
    end

    always_comb
    begin
        nibble = '0;
        for (int d = 0; d < tm1638_pkg::n_digits; d++)
        begin
            if (digit[d])
                nibble = nibble | count[4 * d +: 4];   // digit 0 shows the low nibble
        end
    end

    // segments a..g in bits 7..1, dot in bit 0 stays dark
    always_comb
    begin
        case (nibble)
            4'h0:    abcdefgh = 8'b1111_1100;
            4'h1:    abcdefgh = 8'b0110_0000;
            4'h2:    abcdefgh = 8'b1101_1010;
            4'h3:    abcdefgh = 8'b1111_0010;
            4'h4:    abcdefgh = 8'b0110_0110;
            4'h5:    abcdefgh = 8'b1011_0110;
            4'h6:    abcdefgh = 8'b1011_1110;
            4'h7:    abcdefgh = 8'b1110_0000;
            4'h8:    abcdefgh = 8'b1111_1110;
            4'h9:    abcdefgh = 8'b1111_0110;
            4'ha:    abcdefgh = 8'b1110_1110;
            4'hb:    abcdefgh = 8'b0011_1110;
            4'hc:    abcdefgh = 8'b1001_1100;
            4'hd:    abcdefgh = 8'b0111_1010;
            4'he:    abcdefgh = 8'b1001_1110;
            default: abcdefgh = 8'b1000_1110;
        endcase
    end

endmodule

`default_nettype wire

// File: src/tm1638_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tm1638_ctrl
(
    input  wire        clk,
    input  wire        rst_n,
    output logic       byte_start,
    output logic [7:0] tx_byte,
    output logic       read,
    input  wire        byte_done,
    input  wire  [7:0] rx_byte,
    output logic       sio_stb,
    output logic       frame_load,
    output logic [3:0] data_addr,
    input  wire  [7:0] data_byte,
    output logic       key_wr,
    output logic [1:0] key_idx
);

    tm1638_pkg::ctrl_state_t state;

    logic [1:0] phase;       // 0 open group, 1 issue byte, 2 wait byte, 3 close group
    logic [3:0] byte_cnt;
    logic [4:0] wait_cnt;
    logic       last_byte;

    ////////////////////////////////////////////////////////////////////////////
    // byte selection

    always_comb
    begin
        case (state)
            tm1638_pkg::st_mode:     tx_byte = tm1638_pkg::cmd_write_auto;
            tm1638_pkg::st_addr:     tx_byte = tm1638_pkg::cmd_addr_zero;
            tm1638_pkg::st_data:     tx_byte = data_byte;      // display ram from frame
            tm1638_pkg::st_disp:     tx_byte = tm1638_pkg::cmd_display_on;
            tm1638_pkg::st_read_cmd: tx_byte = tm1638_pkg::cmd_read_keys;
            default:                 tx_byte = 8'hFF;
        endcase
    end

    always_comb
    begin
        case (state)
            tm1638_pkg::st_data: last_byte = int'(byte_cnt) == 2 * tm1638_pkg::n_digits - 1;
            tm1638_pkg::st_read: last_byte = int'(byte_cnt) == tm1638_pkg::n_key_bytes - 1;
            default:             last_byte = 1'b1;
        endcase
    end

    assign read       = state == tm1638_pkg::st_read;
    assign frame_load = state == tm1638_pkg::st_mode && phase == 2'd0;
    assign data_addr  = byte_cnt;
    assign key_wr     = read && phase == 2'd2 && byte_done;    // rx_byte is valid now
    assign key_idx    = byte_cnt[1:0];

    ////////////////////////////////////////////////////////////////////////////
    // refresh sequencer

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= tm1638_pkg::st_idle;
            phase      <= 2'd0;
            byte_cnt   <= '0;
            wait_cnt   <= '0;
            byte_start <= 1'b0;
            sio_stb    <= 1'b1;
        end
        else
        begin
            byte_start <= 1'b0;
            case (state)
                tm1638_pkg::st_idle:
                    state <= tm1638_pkg::st_mode;
                tm1638_pkg::st_gap:
                begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (int'(wait_cnt) == tm1638_pkg::gap_cycles - 1)
                    begin
                        wait_cnt <= '0;
                        phase    <= 2'd0;
                        state    <= tm1638_pkg::st_mode;
                    end
                end
                default:
                begin
                    case (phase)
                        2'd0:
                        begin
                            sio_stb <= 1'b0;           // open the strobe group
                            phase   <= 2'd1;
                        end
                        2'd1:
                        begin
                            byte_start <= 1'b1;
                            phase      <= 2'd2;
                        end
                        2'd2:
                        begin
                            if (byte_done && !last_byte)
                            begin
                                byte_cnt <= byte_cnt + 1'b1;
                                phase    <= 2'd1;
                            end
                            else if (byte_done)
                            begin
                                byte_cnt <= '0;
                                case (state)
                                    tm1638_pkg::st_addr:
                                    begin
                                        state <= tm1638_pkg::st_data;
                                        phase <= 2'd1;
                                    end
                                    tm1638_pkg::st_read_cmd:
                                    begin
                                        state <= tm1638_pkg::st_read;
                                        phase <= 2'd1;
                                    end
                                    default:
                                        phase <= 2'd3;
                                endcase
                            end
                        end
                        default:
                        begin
                            // strobe low for one bit time, then high for one more
                            wait_cnt <= wait_cnt + 1'b1;
                            if (int'(wait_cnt) == 2 * tm1638_pkg::sio_half_div - 1)
                                sio_stb <= 1'b1;
                            if (int'(wait_cnt) == 4 * tm1638_pkg::sio_half_div - 1)
                            begin
                                wait_cnt <= '0;
                                phase    <= 2'd0;
                                case (state)
                                    tm1638_pkg::st_mode: state <= tm1638_pkg::st_addr;
                                    tm1638_pkg::st_data: state <= tm1638_pkg::st_disp;
                                    tm1638_pkg::st_disp: state <= tm1638_pkg::st_read_cmd;
                                    default:             state <= tm1638_pkg::st_gap;
                                endcase
                            end
                        end
                    endcase
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/tm1638_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module tm1638_shifter
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        byte_start,
    input  wire  [7:0] tx_byte,
    input  wire        read,
    output logic       byte_done,
    output logic [7:0] rx_byte,
    output logic       sio_clk,
    output logic       sio_dout,
    output logic       sio_oe,
    input  wire        sio_din
);

    logic [$clog2(tm1638_pkg::sio_half_div) - 1:0] div_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shreg;
    logic       busy;
    logic       rd_mode;
    logic       div_done;

    assign div_done = int'(div_cnt) == tm1638_pkg::sio_half_div - 1;
    assign rx_byte  = shreg;                     // holds the full read byte at byte_done

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy      <= 1'b0;
            rd_mode   <= 1'b0;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            byte_done <= 1'b0;
            sio_clk   <= 1'b1;
            sio_dout  <= 1'b1;
            sio_oe    <= 1'b0;
        end
        else
        begin
            byte_done <= 1'b0;
            if (byte_start)
            begin
                busy     <= 1'b1;
                rd_mode  <= read;
                div_cnt  <= '0;
                bit_cnt  <= '0;
                sio_clk  <= 1'b0;
                sio_oe   <= !read;
                sio_dout <= read ? 1'b1 : tx_byte[0];   // bit 0 goes out with the fall
            end
            else if (busy && !div_done)
                div_cnt <= div_cnt + 1'b1;
            else if (busy)
            begin
                div_cnt <= '0;
                if (!sio_clk)
                    sio_clk <= 1'b1;             // device samples here
                else if (bit_cnt == 3'd7)
                begin
                    busy      <= 1'b0;
                    byte_done <= 1'b1;
                    sio_oe    <= 1'b0;
                    sio_dout  <= 1'b1;
                end
                else
                begin
                    sio_clk <= 1'b0;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (!rd_mode)
                        sio_dout <= shreg[1];    // next bit, lsb first
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (byte_start)
            shreg <= tx_byte;
        else if (busy && div_done && !sio_clk && rd_mode)
            shreg <= {sio_din, shreg[7:1]};      // capture on the rising edge of sio_clk
        else if (busy && div_done && sio_clk && !rd_mode)
            shreg <= {1'b1, shreg[7:1]};
    end

endmodule

`default_nettype wire

// File: src/tm1638_frame.sv
`timescale 1ns/1ps
`default_nettype none

module tm1638_frame
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire  [7:0] hgfedcba,
    input  wire  [7:0] digit,
    input  wire  [7:0] led,
    input  wire        frame_load,
    input  wire  [3:0] data_addr,
    output logic [7:0] data_byte
);

    logic [7:0] slot     [tm1638_pkg::n_digits];
    logic [7:0] snap_seg [tm1638_pkg::n_digits];
    logic [7:0] snap_led;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int d = 0; d < tm1638_pkg::n_digits; d++)
            begin
                slot[d]     <= '0;
                snap_seg[d] <= '0;
            end
            snap_led <= '0;
        end
        else
        begin
            for (int d = 0; d < tm1638_pkg::n_digits; d++)
            begin
                if (digit[d])
                    slot[d] <= hgfedcba;         // catch the scanned digit
                if (frame_load)
                    snap_seg[d] <= slot[d];
            end
            if (frame_load)
                snap_led <= led;
        end
    end

    // even addresses carry segments, odd addresses carry one led in bit 0
    assign data_byte = data_addr[0] ? {7'b0, snap_led[data_addr[3:1]]}
                                    : snap_seg[data_addr[3:1]];

endmodule

`default_nettype wire

// File: src/tm1638_keys.sv
`timescale 1ns/1ps
`default_nettype none

module tm1638_keys
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        key_wr,
    input  wire  [1:0] key_idx,
    input  wire  [7:0] rx_byte,
    output logic [7:0] tm_key
);

    logic [7:0] scan;
    logic [7:0] scan_next;

    always_comb
    begin
        scan_next = scan;
        scan_next[{1'b0, key_idx}] = rx_byte[0];    // keys 0 to 3
        scan_next[{1'b1, key_idx}] = rx_byte[4];    // keys 4 to 7
    end

    always_ff @(posedge clk)
    begin
        if (key_wr)
            scan <= scan_next;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            tm_key <= '0;
        else if (key_wr && int'(key_idx) == tm1638_pkg::n_key_bytes - 1)
            tm_key <= scan_next;                 // publish the whole scan at once
    end

endmodule

`default_nettype wire

// File: src/board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top
(
    input  wire clk,
    input  wire rst_n,
    output wire sio_stb,
    output wire sio_clk,
    output wire sio_dout,
    output wire sio_oe,
    input  wire sio_din
);

    wire       tick;
    wire [7:0] tm_key;
    wire [7:0] lab_led;
    wire [7:0] lab_digit;
    wire [7:0] abcdefgh;
    wire [7:0] hgfedcba;

    wire       byte_start;
    wire [7:0] tx_byte;
    wire       read;
    wire       byte_done;
    wire [7:0] rx_byte;
    wire       frame_load;
    wire [3:0] data_addr;
    wire [7:0] data_byte;
    wire       key_wr;
    wire [1:0] key_idx;

    ////////////////////////////////////////////////////////////////////////////
    // demo side

    tick_gen i_tick_gen (.clk(clk), .rst_n(rst_n), .tick(tick));

    lab_top i_lab_top
    (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .tick     ( tick      ),
        .key      ( tm_key    ),
        .led      ( lab_led   ),
        .abcdefgh ( abcdefgh  ),
        .digit    ( lab_digit )
    );

    // the module expects segment a in bit 0
    for (genvar i = 0; i < 8; i++)
    begin : g_rev
        assign hgfedcba[i] = abcdefgh[7 - i];
    end

    ////////////////////////////////////////////////////////////////////////////
    // TM1638 controller

    tm1638_ctrl i_ctrl
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .byte_start ( byte_start ),
        .tx_byte    ( tx_byte    ),
        .read       ( read       ),
        .byte_done  ( byte_done  ),
        .rx_byte    ( rx_byte    ),
        .sio_stb    ( sio_stb    ),
        .frame_load ( frame_load ),
        .data_addr  ( data_addr  ),
        .data_byte  ( data_byte  ),
        .key_wr     ( key_wr     ),
        .key_idx    ( key_idx    )
    );

    tm1638_shifter i_shifter
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .byte_start ( byte_start ),
        .tx_byte    ( tx_byte    ),
        .read       ( read       ),
        .byte_done  ( byte_done  ),
        .rx_byte    ( rx_byte    ),
        .sio_clk    ( sio_clk    ),
        .sio_dout   ( sio_dout   ),
        .sio_oe     ( sio_oe     ),
        .sio_din    ( sio_din    )
    );

    tm1638_frame i_frame
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .hgfedcba   ( hgfedcba   ),
        .digit      ( lab_digit  ),
        .led        ( lab_led    ),
        .frame_load ( frame_load ),
        .data_addr  ( data_addr  ),
        .data_byte  ( data_byte  )
    );

    tm1638_keys i_keys
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .key_wr     ( key_wr     ),
        .key_idx    ( key_idx    ),
        .rx_byte    ( rx_byte    ),
        .tm_key     ( tm_key     )
    );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
    parameter real period_ns = 100.0
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(period_ns / 2.0) clk = ~clk;   // free running, starts low
    end

endmodule

`default_nettype wire

// File: tb/tb_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_monitor
(
    input  wire       clk,
    input  wire       rst_n,
    input  wire       sio_stb,
    input  wire       sio_clk,
    input  wire       sio_dout,
    input  wire       sio_oe,
    input  wire [7:0] key_pat,
    output int        n_errors,
    output int        n_checks,
    output int        n_refresh
);

    logic        prev_stb;
    logic        prev_sclk;
    logic        prev_rst_n;
    logic        stb_seen;
    logic [7:0]  shreg;
    int          bit_cnt;
    int          n_bytes;
    logic [7:0]  wr_bytes [17];
    int          group;
    int          since_reset;
    logic [7:0]  cur_pat;
    logic [7:0]  prev_pat;
    logic [31:0] prev_val;
    logic [31:0] first_val;
    logic [7:0]  seen_hi;
    logic [7:0]  seen_lo;

    initial
    begin
        n_errors   = 0;
        n_checks   = 0;
        n_refresh  = 0;
        prev_stb   = 1'b1;
        prev_sclk  = 1'b1;
        prev_rst_n = 1'b1;
        stb_seen   = 1'b0;
        seen_hi    = '0;
        seen_lo    = '0;
        prev_pat   = '0;
        cur_pat    = '0;
        prev_val   = '0;
        first_val  = '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [7:0] reverse_bits(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = b[7 - i];
        return r;
    endfunction

    // a..g in bits 7..1, dot in bit 0 must be dark
    function automatic int decode_hex(input logic [7:0] seg);
        case (seg)
            8'b1111_1100: return 0;
            8'b0110_0000: return 1;
            8'b1101_1010: return 2;
            8'b1111_0010: return 3;
            8'b0110_0110: return 4;
            8'b1011_0110: return 5;
            8'b1011_1110: return 6;
            8'b1110_0000: return 7;
            8'b1111_1110: return 8;
            8'b1111_0110: return 9;
            8'b1110_1110: return 10;
            8'b0011_1110: return 11;
            8'b1001_1100: return 12;
            8'b0111_1010: return 13;
            8'b1001_1110: return 14;
            8'b1000_1110: return 15;
            default:      return -1;
        endcase
    endfunction

    task automatic check(input logic ok, input string msg);
        n_checks++;
        if (ok !== 1'b1)
        begin
            n_errors++;
            $display("Fail %0t: %s", $time, msg);
        end
    endtask

    task automatic check_idle_pins(input string where);
        check(sio_stb && sio_clk && sio_dout && !sio_oe,
              $sformatf("%s: pins stb %b clk %b dout %b oe %b, expected 1 1 1 0",
                        where, sio_stb, sio_clk, sio_dout, sio_oe));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // frame checks

    // wr_bytes[1..16] still hold the data group, later groups only touch byte 0
    task automatic check_display();
        logic [31:0] val;
        logic [7:0]  seg;
        logic [7:0]  exp_led;
        int          nib;
        val     = '0;
        exp_led = (since_reset == 0) ? 8'h00 : prev_pat;    // leds lag the scan by one refresh
        for (int d = 0; d < tm1638_pkg::n_digits; d++)
        begin
            seg = reverse_bits(wr_bytes[1 + 2 * d]);
            nib = decode_hex(seg);
            if (since_reset == 0)
                check(seg == 8'h00 || nib == 0,
                      $sformatf("digit %0d shows %02h in the first refresh", d, seg));
            else
            begin
                check(nib >= 0, $sformatf("digit %0d is not a hex pattern: %02h", d, seg));
                if (nib >= 0)
                    val[4 * d +: 4] = nib[3:0];
            end
            check(wr_bytes[2 + 2 * d] == {7'b0, exp_led[d]},
                  $sformatf("led byte %0d is %02h, expected %02h",
                            d, wr_bytes[2 + 2 * d], {7'b0, exp_led[d]}));
        end
        if (since_reset == 1)
        begin
            check(val == 0, $sformatf("value after reset is %08h, expected 0", val));
            first_val = val;
        end
        else if (since_reset > 1)
            check(val == prev_val || val == prev_val + 1,
                  $sformatf("value %08h does not follow %08h", val, prev_val));
        if (since_reset > 0)
        begin
            prev_val = val;
            seen_hi  = seen_hi | exp_led;
            seen_lo  = seen_lo | ~exp_led;
        end
        prev_pat = cur_pat;
        since_reset++;
    endtask

    task automatic end_group();
        tm1638_pkg::tm_cmd_t exp_cmd;
        int                  exp_n;
        case (group)
            0:
            begin
                exp_cmd = tm1638_pkg::cmd_write_auto;
                exp_n   = 1;
            end
            1:
            begin
                exp_cmd = tm1638_pkg::cmd_addr_zero;
                exp_n   = 1 + 2 * tm1638_pkg::n_digits;
            end
            2:
            begin
                exp_cmd = tm1638_pkg::cmd_display_on;
                exp_n   = 1;
            end
            default:
            begin
                exp_cmd = tm1638_pkg::cmd_read_keys;
                exp_n   = 1;                      // read bytes come in with oe low
            end
        endcase
        check(n_bytes == exp_n && wr_bytes[0] == exp_cmd,
              $sformatf("group %0d has %0d bytes starting %02h, expected %0d starting %02h",
                        group, n_bytes, wr_bytes[0], exp_n, exp_cmd));
        if (group == 3)
        begin
            check_display();
            n_refresh++;
            group = 0;
        end
        else
            group++;
    endtask

    task automatic check_progress();
        check(prev_val > first_val,
              $sformatf("display value stayed at %08h during the run", prev_val));
    endtask

    task automatic check_coverage();
        check(&seen_hi && &seen_lo,
              $sformatf("keys not covered, seen high %02h seen low %02h", seen_hi, seen_lo));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // serial decoder

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            if (!prev_rst_n)
                check_idle_pins("in reset");     // pins have had a full cycle of reset
            stb_seen    = 1'b0;
            group       = 0;
            n_bytes     = 0;
            bit_cnt     = 0;
            since_reset = 0;
        end
        else
        begin
            if (!sio_stb)
                stb_seen = 1'b1;
            if (!stb_seen)
                check_idle_pins("before first strobe");
            if (prev_stb && !sio_stb)
            begin
                n_bytes = 0;
                bit_cnt = 0;
            end
            if (sio_clk && !prev_sclk && !sio_stb && sio_oe)
            begin
                shreg = {sio_dout, shreg[7:1]};   // lsb first
                bit_cnt++;
                if (bit_cnt == 8)
                begin
                    if (n_bytes < 17)
                        wr_bytes[n_bytes] = shreg;
                    n_bytes++;
                    bit_cnt = 0;
                    if (n_bytes == 1 && shreg == tm1638_pkg::cmd_read_keys)
                        cur_pat = key_pat;        // pattern the device answers with
                end
            end
            if (sio_stb && !prev_stb && stb_seen)
                end_group();
        end
        prev_stb   = sio_stb;
        prev_sclk  = sio_clk;
        prev_rst_n = rst_n;
    end

endmodule

`default_nettype wire

// File: tb/board_top_chk.sv
`timescale 1ns/1ps
`default_nettype none

module board_top_chk
(
    input wire clk,
    input wire rst_n,
    input wire sio_stb,
    input wire sio_clk,
    input wire sio_oe,
    input wire read,
    input wire byte_start,
    input wire byte_done
);

    logic busy;
    int   n_fail = 0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            busy <= 1'b0;
        else if (byte_start)
            busy <= 1'b1;
        else if (byte_done)
            busy <= 1'b0;                        // clears as the last bit completes
    end

    a_stb_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sio_stb) |-> !busy)
        else
        begin
            n_fail++;
            $error("sio_stb rose in the middle of a byte");
        end

    a_read_oe: assert property (@(posedge clk) disable iff (!rst_n)
        (!sio_stb && read) |-> !sio_oe)
        else
        begin
            n_fail++;
            $error("sio_oe driven during the key read phase");
        end

    a_clk_high: assert property (@(posedge clk) disable iff (!rst_n)
        sio_stb |-> sio_clk)
        else
        begin
            n_fail++;
            $error("sio_clk low while sio_stb is high");
        end

endmodule

bind board_top board_top_chk u_chk
(
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .sio_stb    ( sio_stb    ),
    .sio_clk    ( sio_clk    ),
    .sio_oe     ( sio_oe     ),
    .read       ( read       ),
    .byte_start ( byte_start ),
    .byte_done  ( byte_done  )
);

`default_nettype wire

// File: tb/tb_board_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_top;

    // one refresh: 24 bytes, 4 strobe groups and the gap
    localparam int byte_cycles    = 16 * tm1638_pkg::sio_half_div + 2;
    localparam int group_cycles   = 1 + 4 * tm1638_pkg::sio_half_div;
    localparam int refresh_cycles = 24 * byte_cycles + 4 * group_cycles
                                    + tm1638_pkg::gap_cycles + 1;
    localparam int timeout_cycles = 40 * refresh_cycles + 64;

    wire        clk;
    logic       rst_n;
    wire        sio_stb;
    wire        sio_clk;
    wire        sio_dout;
    wire        sio_oe;
    logic       sio_din;

    logic [31:0] lfsr;
    logic [7:0]  key_pat;
    int          cycles;
    int          n_errors;
    int          n_checks;
    int          n_refresh;
    int          err_base;
    int          ref_base;
    int          n_failed;

    // device model state
    logic       dev_prev_stb;
    logic       dev_prev_sclk;
    logic [7:0] dev_cmd;
    int         dev_bits;
    logic       dev_read;
    int         dev_rd_bit;
    logic       dev_din;

    tb_clock #(.period_ns(100.0)) u_clock (.clk(clk));

    board_top UUT
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .sio_stb  ( sio_stb  ),
        .sio_clk  ( sio_clk  ),
        .sio_dout ( sio_dout ),
        .sio_oe   ( sio_oe   ),
        .sio_din  ( sio_din  )
    );

    tb_monitor u_mon
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .sio_stb   ( sio_stb   ),
        .sio_clk   ( sio_clk   ),
        .sio_dout  ( sio_dout  ),
        .sio_oe    ( sio_oe    ),
        .key_pat   ( key_pat   ),
        .n_errors  ( n_errors  ),
        .n_checks  ( n_checks  ),
        .n_refresh ( n_refresh )
    );

    ////////////////////////////////////////////////////////////////////////////
    // key pattern source

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    task automatic draw_key_pattern();
        for (int i = 0; i < 8; i++)
        begin
            lfsr       = lfsr_next(lfsr);
            key_pat[i] = lfsr[0];
        end
    endtask

    // key i sits in bit 0 of byte i, key i+4 in bit 4
    function automatic logic key_bit(input int idx);
        case (idx % 8)
            0:       return key_pat[idx / 8];
            4:       return key_pat[idx / 8 + 4];
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // TM1638 device model

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            dev_bits   = 0;
            dev_read   = 1'b0;
            dev_rd_bit = 0;
            dev_din    = 1'b0;
        end
        else
        begin
            if (dev_prev_stb && !sio_stb)
            begin
                dev_bits   = 0;
                dev_read   = 1'b0;
                dev_rd_bit = 0;
            end
            if (sio_clk && !dev_prev_sclk && !sio_stb && sio_oe && dev_bits < 8)
            begin
                dev_cmd = {sio_dout, dev_cmd[7:1]};
                dev_bits++;
                if (dev_bits == 8 && dev_cmd == tm1638_pkg::cmd_read_keys)
                    dev_read = 1'b1;
            end
            if (!sio_clk && dev_prev_sclk && !sio_stb && dev_read && !sio_oe)
            begin
                dev_din = key_bit(dev_rd_bit);   // next bit after the falling edge
                dev_rd_bit++;
            end
            if (sio_stb && !dev_prev_stb && dev_read)
            begin
                draw_key_pattern();              // new pattern for the next refresh
                dev_read = 1'b0;
            end
        end
        dev_prev_stb  = sio_stb;
        dev_prev_sclk = sio_clk;
        #10;
        sio_din = dev_din;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= timeout_cycles)
        begin
            $display("timeout: refreshes stopped completing after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        #10;
        rst_n = 1'b0;
        repeat (16)
            @(posedge clk);
        #10;
        rst_n = 1'b1;
    endtask

    task automatic report_test(input string name);
        $display("test %s done: %0d refreshes, %0d errors",
                 name, n_refresh - ref_base, n_errors - err_base);
        if (n_errors != err_base)
            n_failed++;
        err_base = n_errors;
        ref_base = n_refresh;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial
    begin
        rst_n         = 1'b0;
        sio_din       = 1'b0;
        cycles        = 0;
        err_base      = 0;
        ref_base      = 0;
        n_failed      = 0;
        dev_prev_stb  = 1'b1;
        dev_prev_sclk = 1'b1;
        dev_cmd       = '0;
        lfsr          = 32'ha5eaca9f;
        draw_key_pattern();
        repeat (16)
            @(posedge clk);
        #10;
        rst_n = 1'b1;

        wait (n_refresh >= 20);
        u_mon.check_progress();
        report_test("refresh_run");

        apply_reset();
        wait (n_refresh >= ref_base + 6);
        report_test("midrun_reset");

        u_mon.check_coverage();
        report_test("key_coverage");

        $display("tests 3, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 n_failed, n_checks, n_errors, UUT.u_chk.n_fail);
        if (n_errors == 0 && UUT.u_chk.n_fail == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
src/tm1638_pkg.sv
src/tick_gen.sv
src/lab_top.sv
src/tm1638_ctrl.sv
src/tm1638_shifter.sv
src/tm1638_frame.sv
src/tm1638_keys.sv
src/board_top.sv
tb/tb_clock.sv
tb/tb_monitor.sv
tb/board_top_chk.sv
tb/tb_board_top.sv

// File: Bender.yml
package:
  name: tm1638_board

sources:
  - src/tm1638_pkg.sv
  - src/tick_gen.sv
  - src/lab_top.sv
  - src/tm1638_ctrl.sv
  - src/tm1638_shifter.sv
  - src/tm1638_frame.sv
  - src/tm1638_keys.sv
  - src/board_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/tb_monitor.sv
      - tb/board_top_chk.sv
      - tb/tb_board_top.sv
